// File: Bender.yml
package:
  name: qtu_fmb

sources:
  # packages come first, every module imports them
  - logic/routingTypesPkg.sv
  - logic/neighborTablePkg.sv
  - logic/packetIf.sv
  - logic/clusterConfig.sv
  - logic/neighborTable.sv
  - logic/nextHopSelect.sv
  - logic/qtuFmbTop.sv

  - target: test
    files:
      - tests/clockGen.sv
      - tests/qtuFmb_assertions.sv
      - tests/qtuFmbTb.sv

// File: logic/clusterConfig.sv
module clusterConfig import routingTypesPkg::*; (
    input  logic     clk,
    input  logic     nrst,
    input  logic     cfgWrite,
    input  nodeIdT   cfgChosenCH,
    input  hopCountT cfgHopsFromCH,
    output nodeIdT   chosenCH,
    output hopCountT hopTarget
);

    // own distance to the cluster head
    hopCountT hopsFromCH;

    // node starts with no cluster and no distance
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            chosenCH   <= NoNode;
            hopsFromCH <= NoHop;
        end else if (cfgWrite) begin
            chosenCH   <= cfgChosenCH;
            hopsFromCH <= cfgHopsFromCH;
        end
    end

    // distance a usable next hop must have
    always_comb begin
        if (hopsFromCH == NoHop) begin
            // unknown distance stays unknown
            hopTarget = NoHop;
        end else if (hopsFromCH == '0) begin
            // saturate, the cluster head itself
            hopTarget = '0;
        end else begin
            hopTarget = hopsFromCH - hopCountT'(1);
        end
    end

endmodule

// File: logic/neighborTable.sv
module neighborTable import neighborTablePkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic              hbReset,
    packetIf.tableView        pkt,
    output slotIndexT         slotIndex,
    output logic              written
);

    // slot occupancy and stored sender IDs
    logic [TableDepth-1:0] valid;
    idStoreT               ids;

    logic      hit;
    logic      freeFound;
    logic      doWrite;
    slotIndexT hitIndex;
    slotIndexT freeIndex;
    slotIndexT target;

    // ID match against every valid slot, lowest matching slot wins
    always_comb begin
        hit      = 1'b0;
        hitIndex = FirstSlot;
        for (int i = TableDepth - 1; i >= 0; i--) begin
            if (valid[i] && (ids[i] == pkt.sourceId)) begin
                hit      = 1'b1;
                hitIndex = slotIndexT'(i);
            end
        end
    end

    // lowest empty slot for a new sender
    always_comb begin
        freeFound = 1'b0;
        freeIndex = FirstSlot;
        for (int i = TableDepth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                freeFound = 1'b1;
                freeIndex = slotIndexT'(i);
            end
        end
    end

    // hit reuses its slot, a miss claims a free one
    assign target = hit ? hitIndex : freeIndex;

    // full table plus miss, nothing to write
    // heartbeat on the same edge wins over the write
    assign doWrite = pkt.process && (hit || freeFound) && !hbReset;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid <= '0;
        end else if (hbReset) begin
            // recluster, every neighbor forgotten
            valid <= '0;
        end else if (doWrite) begin
            valid[target] <= 1'b1;
        end
    end

    // ID store, only meaningful where valid is set
    always_ff @(posedge clk) begin
        if (doWrite) begin
            ids[target] <= pkt.sourceId;
        end
    end

    // result of the process step, read by the top at the output step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            written   <= 1'b0;
            slotIndex <= FirstSlot;
        end else begin
            written <= doWrite;
            if (pkt.process) begin
                slotIndex <= target;
            end
        end
    end

endmodule

// File: logic/neighborTablePkg.sv
package neighborTablePkg;

    import routingTypesPkg::*;

    // neighbor slots per node
    localparam int TableDepth = 32;

    // bits of a slot number
    localparam int SlotBits = $clog2(TableDepth);

    typedef logic [SlotBits-1:0] slotIndexT;

    // one stored sender ID per slot
    typedef nodeIdT idStoreT [TableDepth];

    // default index when a lookup finds nothing
    localparam slotIndexT FirstSlot = '0;

endpackage

// File: logic/nextHopSelect.sv
module nextHopSelect import routingTypesPkg::*; (
    input  logic     clk,
    input  logic     nrst,
    input  logic     hbReset,
    packetIf.selector pkt,
    input  hopCountT hopTarget,
    input  nodeIdT   chosenCH,
    input  logic     outputStep,
    output nodeIdT   nextHop,
    output hopCountT nextHopCount
);

    // best sender so far at the target distance
    nodeIdT bestId;
    qValueT bestQ;

    logic candidate;
    logic better;

    // only data for us, from one hop closer to the cluster head
    assign candidate = pkt.process && pkt.iAmDestination
                       && (pkt.hopsFromCH == hopTarget);

    // higher Q wins, tie goes to the lower ID
    assign better = (pkt.qValue > bestQ)
                    || ((pkt.qValue == bestQ) && (pkt.sourceId < bestId));

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bestId <= NoNode;
            bestQ  <= '0;
        end else if (hbReset) begin
            bestId <= NoNode;
            bestQ  <= '0;
        end else if (candidate && better) begin
            bestId <= pkt.sourceId;
            bestQ  <= pkt.qValue;
        end
    end

    // published once per packet at the output step
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nextHop      <= '0;
            nextHopCount <= NoHop;
        end else if (hbReset) begin
            nextHop      <= '0;
            nextHopCount <= NoHop;
        end else if (outputStep) begin
            // one hop out, send straight to the cluster head
            nextHop      <= (hopTarget == '0) ? chosenCH : bestId;
            nextHopCount <= hopTarget;
        end
    end

endmodule

// File: logic/packetIf.sv
interface packetIf import routingTypesPkg::*; ();

    // accepted packet, held stable until the next accept
    nodeIdT   sourceId;
    qValueT   qValue;
    hopCountT hopsFromCH;
    nodeIdT   chosenCH;
    logic     iAmDestination;

    // one-cycle strobe, only for packets of our own cluster
    logic     process;

    modport sequencer (
        output sourceId, qValue, hopsFromCH, chosenCH, iAmDestination, process
    );

    // table only needs the ID to look up or allocate
    modport tableView (
        input sourceId, process
    );

    modport selector (
        input sourceId, qValue, hopsFromCH, chosenCH, iAmDestination, process
    );

endinterface

// File: logic/qtuFmbTop.sv
module qtuFmbTop import routingTypesPkg::*, neighborTablePkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  logic      cfgWrite,
    input  nodeIdT    cfgChosenCH,
    input  hopCountT  cfgHopsFromCH,
    input  logic      hbReset,
    input  logic      pktValid,
    output logic      pktReady,
    input  nodeIdT    sourceId,
    input  qValueT    qValue,
    input  hopCountT  hopsFromCH,
    input  nodeIdT    chosenCH,
    input  logic      iAmDestination,
    output nodeIdT    recordId,
    output qValueT    recordQValue,
    output slotIndexT recordIndex,
    output logic      recordWritten,
    output logic      done,
    output nodeIdT    nextHop,
    output hopCountT  nextHopCount
);

    packetIf pktBus ();

    // sequencer, idle when neither step flag is set
    logic armed;
    logic processStep;
    logic outputStep;
    logic accept;

    nodeIdT    nodeCH;
    hopCountT  hopTarget;
    slotIndexT slotIndex;
    logic      written;

    // armed keeps ready low in the first cycle out of reset
    assign pktReady = armed && !processStep && !outputStep;
    assign accept   = pktValid && pktReady;

    // idle -> process -> output -> idle, one packet in flight
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            armed       <= 1'b0;
            processStep <= 1'b0;
            outputStep  <= 1'b0;
            done        <= 1'b0;
        end else begin
            armed       <= 1'b1;
            processStep <= accept;
            outputStep  <= processStep;
            done        <= outputStep;
        end
    end

    // capture the packet on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            pktBus.sourceId       <= sourceId;
            pktBus.qValue         <= qValue;
            pktBus.hopsFromCH     <= hopsFromCH;
            pktBus.chosenCH       <= chosenCH;
            pktBus.iAmDestination <= iAmDestination;
        end
    end

    // foreign cluster packets still step through, but never process
    assign pktBus.process = processStep && (pktBus.chosenCH == nodeCH);

    // neighbor record, written flag follows the table result
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            recordWritten <= 1'b0;
        end else if (outputStep) begin
            recordWritten <= written;
        end
    end

    always_ff @(posedge clk) begin
        if (outputStep) begin
            recordId     <= pktBus.sourceId;
            recordQValue <= pktBus.qValue;
            recordIndex  <= slotIndex;
        end
    end

    clusterConfig cfg_i (
        .clk           (clk),
        .nrst          (nrst),
        .cfgWrite      (cfgWrite),
        .cfgChosenCH   (cfgChosenCH),
        .cfgHopsFromCH (cfgHopsFromCH),
        .chosenCH      (nodeCH),
        .hopTarget     (hopTarget)
    );

    neighborTable table_i (
        .clk       (clk),
        .nrst      (nrst),
        .hbReset   (hbReset),
        .pkt       (pktBus),
        .slotIndex (slotIndex),
        .written   (written)
    );

    nextHopSelect select_i (
        .clk          (clk),
        .nrst         (nrst),
        .hbReset      (hbReset),
        .pkt          (pktBus),
        .hopTarget    (hopTarget),
        .chosenCH     (nodeCH),
        .outputStep   (outputStep),
        .nextHop      (nextHop),
        .nextHopCount (nextHopCount)
    );

endmodule

// File: logic/routingTypesPkg.sv
package routingTypesPkg;

    // every packet field is one word
    localparam int WordWidth = 16;

    // node address
    typedef logic [WordWidth-1:0] nodeIdT;

    // hop distance to the cluster head
    typedef logic [WordWidth-1:0] hopCountT;

    // learned Q value of a node
    typedef logic [WordWidth-1:0] qValueT;

    // hop distance not known yet
    localparam hopCountT NoHop = '1;

    // no next-hop candidate seen
    localparam nodeIdT NoNode = '1;

endpackage

// File: sim.f
logic/routingTypesPkg.sv
logic/neighborTablePkg.sv
logic/packetIf.sv
logic/clusterConfig.sv
logic/neighborTable.sv
logic/nextHopSelect.sv
logic/qtuFmbTop.sv
tests/clockGen.sv
tests/qtuFmb_assertions.sv
tests/qtuFmbTb.sv

// File: tests/clockGen.sv
module clockGen (
    output logic clk,
    output logic nrst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    localparam int HalfPeriod  = 10;
    localparam int ResetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        nrst = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

// File: tests/qtuFmbTb.sv
module qtuFmbTb import routingTypesPkg::*, neighborTablePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // row kinds
    localparam int OpIdle      = 0;
    localparam int OpConfig    = 1;
    localparam int OpPacket    = 2;
    localparam int OpHeartbeat = 3;
    localparam int OpRandom    = 4;

    // cycles allowed for any single wait
    localparam int WaitLimit = 50;
    localparam int DrawLimit = 1000;

    // own cluster head, a foreign one, and the head used one hop out
    localparam nodeIdT HomeCH  = 16'h00C0;
    localparam nodeIdT OtherCH = 16'h00D0;
    localparam nodeIdT NearCH  = 16'h00E0;

    typedef struct {
        int       kind;
        string    name;
        nodeIdT   srcId;
        qValueT   qVal;
        hopCountT hops;
        nodeIdT   ch;
        logic     dest;
        int       count;
        logic     expWritten;
        int       expIndex;
        nodeIdT   expNextHop;
        hopCountT expHopCount;
    } rowT;

    rowT    rows[$];
    nodeIdT usedIds[$];
    integer seed;
    int     rowErrors;
    int     failedTests;
    int     testsRun;
    bit     timedOut;

    logic      clk;
    logic      nrst;
    logic      cfgWrite;
    nodeIdT    cfgChosenCH;
    hopCountT  cfgHopsFromCH;
    logic      hbReset;
    logic      pktValid;
    logic      pktReady;
    nodeIdT    sourceId;
    qValueT    qValue;
    hopCountT  hopsFromCH;
    nodeIdT    chosenCH;
    logic      iAmDestination;
    nodeIdT    recordId;
    qValueT    recordQValue;
    slotIndexT recordIndex;
    logic      recordWritten;
    logic      done;
    nodeIdT    nextHop;
    hopCountT  nextHopCount;

    clockGen clocks_i (
        .clk  (clk),
        .nrst (nrst)
    );

    qtuFmbTop dut_i (
        .clk            (clk),
        .nrst           (nrst),
        .cfgWrite       (cfgWrite),
        .cfgChosenCH    (cfgChosenCH),
        .cfgHopsFromCH  (cfgHopsFromCH),
        .hbReset        (hbReset),
        .pktValid       (pktValid),
        .pktReady       (pktReady),
        .sourceId       (sourceId),
        .qValue         (qValue),
        .hopsFromCH     (hopsFromCH),
        .chosenCH       (chosenCH),
        .iAmDestination (iAmDestination),
        .recordId       (recordId),
        .recordQValue   (recordQValue),
        .recordIndex    (recordIndex),
        .recordWritten  (recordWritten),
        .done           (done),
        .nextHop        (nextHop),
        .nextHopCount   (nextHopCount)
    );

    task automatic addRow(input int kind, input string name, input nodeIdT srcId,
                          input qValueT qVal, input hopCountT hops, input nodeIdT ch,
                          input logic dest, input int count, input logic expWritten,
                          input int expIndex, input nodeIdT expNextHop,
                          input hopCountT expHopCount);
        rowT row;
        row = '{kind, name, srcId, qVal, hops, ch, dest, count, expWritten, expIndex,
                expNextHop, expHopCount};
        rows.push_back(row);
    endtask

    // kind, name, id, q, hops, ch, dest, count, written, index, nextHop, nextHopCount
    task automatic buildTable();
        addRow(OpIdle, "reset state", 0, 0, 0, 0, 0, 0, 0, 0, 0, NoHop);
        addRow(OpConfig, "config hop 3", 0, 0, 3, HomeCH, 0, 0, 0, 0, 0, 0);
        // new senders fill slots in order, no candidate yet
        addRow(OpPacket, "new sender a", 'h0101, 'h0010, 5, HomeCH, 0, 1, 1, 0, NoNode, 2);
        addRow(OpPacket, "new sender b", 'h0102, 'h0011, 5, HomeCH, 0, 1, 1, 1, NoNode, 2);
        // foreign cluster, not stored, so sender c still lands in slot 2
        addRow(OpPacket, "foreign sender", 'h0200, 'h0013, 5, OtherCH, 0, 1, 0, 0, NoNode, 2);
        addRow(OpPacket, "new sender c", 'h0103, 'h0012, 5, HomeCH, 0, 1, 1, 2, NoNode, 2);
        addRow(OpPacket, "repeat sender b", 'h0102, 'h0020, 5, HomeCH, 0, 1, 1, 1, NoNode, 2);
        addRow(OpPacket, "foreign id at home", 'h0200, 'h0014, 5, HomeCH, 0, 1, 1, 3, NoNode, 2);
        // best next hop at distance 2
        addRow(OpPacket, "first candidate", 'h0301, 'h0040, 2, HomeCH, 1, 1, 1, 4, 'h0301, 2);
        addRow(OpPacket, "lower q", 'h0302, 'h0030, 2, HomeCH, 1, 1, 1, 5, 'h0301, 2);
        addRow(OpPacket, "wrong distance", 'h0303, 'h0080, 3, HomeCH, 1, 1, 1, 6, 'h0301, 2);
        addRow(OpPacket, "not destination", 'h0304, 'h0050, 2, HomeCH, 0, 1, 1, 7, 'h0301, 2);
        addRow(OpPacket, "higher q", 'h0305, 'h0060, 2, HomeCH, 1, 1, 1, 8, 'h0305, 2);
        addRow(OpPacket, "tie lower id", 'h0300, 'h0060, 2, HomeCH, 1, 1, 1, 9, 'h0300, 2);
        addRow(OpPacket, "tie higher id", 'h0306, 'h0060, 2, HomeCH, 1, 1, 1, 10, 'h0300, 2);
        addRow(OpPacket, "closer distance", 'h0307, 'h0090, 1, HomeCH, 1, 1, 1, 11, 'h0300, 2);
        // one hop out, cluster head is the next hop
        addRow(OpConfig, "config hop 1", 0, 0, 1, NearCH, 0, 0, 0, 0, 0, 0);
        addRow(OpPacket, "direct to head", 'h0401, 'h0005, 0, NearCH, 1, 1, 1, 12, NearCH, 0);
        // full table, then heartbeat
        addRow(OpHeartbeat, "heartbeat empties", 0, 0, 0, 0, 0, 0, 0, 0, 0, NoHop);
        addRow(OpRandom, "fill 32 slots", 0, 'h0011, 0, NearCH, 0, 32, 1, 0, NearCH, 0);
        addRow(OpRandom, "table full", 0, 'h0011, 0, NearCH, 0, 1, 0, 0, NearCH, 0);
        addRow(OpHeartbeat, "heartbeat clears", 0, 0, 0, 0, 0, 0, 0, 0, 0, NoHop);
        addRow(OpRandom, "slot 0 reused", 0, 'h0011, 0, NearCH, 0, 1, 1, 0, NearCH, 0);
    endtask

    task automatic checkValue(input string sig, input logic [WordWidth-1:0] got,
                              input logic [WordWidth-1:0] exp);
        assert (got === exp)
        else begin
            $display("Error %s: got %h, expected %h", sig, got, exp);
            rowErrors++;
        end
    endtask

    task automatic waitReset();
        int n;
        n = 0;
        while (nrst !== 1'b1 && n < WaitLimit) begin
            @(posedge clk);
            n++;
        end
        if (nrst !== 1'b1) begin
            $display("reset was never released");
            timedOut = 1'b1;
        end
        @(negedge clk);
    endtask

    task automatic writeConfig(input nodeIdT ch, input hopCountT hops);
        cfgChosenCH   = ch;
        cfgHopsFromCH = hops;
        cfgWrite      = 1'b1;
        @(negedge clk);
        cfgWrite = 1'b0;
    endtask

    task automatic pulseHeartbeat();
        hbReset = 1'b1;
        @(negedge clk);
        hbReset = 1'b0;
    endtask

    // fresh sender ID, never drawn before in this run
    task automatic drawId(output nodeIdT id);
        int  tries;
        bit  clash;
        tries = 0;
        do begin
            id    = nodeIdT'($random(seed));
            clash = 1'b0;
            foreach (usedIds[i]) begin
                if (usedIds[i] == id) begin
                    clash = 1'b1;
                end
            end
            tries++;
        end while (clash && tries < DrawLimit);
        if (clash) begin
            $display("could not draw a fresh sender ID");
            rowErrors++;
        end
        usedIds.push_back(id);
    endtask

    // hold valid until accepted, then wait for the done pulse
    task automatic sendPacket(input nodeIdT id, input qValueT q, input hopCountT hops,
                              input nodeIdT ch, input logic dest);
        int n;
        sourceId       = id;
        qValue         = q;
        hopsFromCH     = hops;
        chosenCH       = ch;
        iAmDestination = dest;
        pktValid       = 1'b1;
        n = 0;
        while (!pktReady && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!pktReady) begin
            $display("pktReady never rose for sender %h", id);
            timedOut = 1'b1;
            return;
        end
        // accepted on the rising edge in between
        @(negedge clk);
        pktValid = 1'b0;
        n = 0;
        while (!done && n < WaitLimit) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("done never came for sender %h", id);
            timedOut = 1'b1;
        end
    endtask

    task automatic checkResult(input rowT row, input nodeIdT id, input int index);
        checkValue("recordWritten", recordWritten, row.expWritten);
        // index only means something when a slot was written
        if (row.expWritten) begin
            checkValue("recordIndex", recordIndex, index);
        end
        checkValue("recordId", recordId, id);
        checkValue("recordQValue", recordQValue, row.qVal);
        checkValue("nextHop", nextHop, row.expNextHop);
        checkValue("nextHopCount", nextHopCount, row.expHopCount);
    endtask

    task automatic applyRow(input rowT row);
        nodeIdT id;
        int     k;
        case (row.kind)
            OpIdle: begin
                checkValue("done", done, 1'b0);
                checkValue("recordWritten", recordWritten, row.expWritten);
                checkValue("nextHop", nextHop, row.expNextHop);
                checkValue("nextHopCount", nextHopCount, row.expHopCount);
            end
            OpConfig: begin
                writeConfig(row.ch, row.hops);
            end
            OpPacket: begin
                sendPacket(row.srcId, row.qVal, row.hops, row.ch, row.dest);
                if (!timedOut) begin
                    checkResult(row, row.srcId, row.expIndex);
                end
            end
            OpHeartbeat: begin
                pulseHeartbeat();
                checkValue("nextHop", nextHop, row.expNextHop);
                checkValue("nextHopCount", nextHopCount, row.expHopCount);
            end
            OpRandom: begin
                // consecutive slots from expIndex on
                for (k = 0; k < row.count && !timedOut; k++) begin
                    drawId(id);
                    sendPacket(id, row.qVal, row.hops, row.ch, row.dest);
                    if (!timedOut) begin
                        checkResult(row, id, row.expIndex + k);
                    end
                end
            end
            default: begin
                $display("unknown row kind %0d", row.kind);
                rowErrors++;
            end
        endcase
    endtask

    initial begin
        int r;
        int assertFails;
        seed           = 32'h3028ba99;
        rowErrors      = 0;
        failedTests    = 0;
        testsRun       = 0;
        timedOut       = 1'b0;
        cfgWrite       = 1'b0;
        cfgChosenCH    = '0;
        cfgHopsFromCH  = '0;
        hbReset        = 1'b0;
        pktValid       = 1'b0;
        sourceId       = '0;
        qValue         = '0;
        hopsFromCH     = '0;
        chosenCH       = '0;
        iAmDestination = 1'b0;
        buildTable();
        waitReset();
        for (r = 0; r < rows.size() && !timedOut; r++) begin
            rowErrors = 0;
            applyRow(rows[r]);
            testsRun++;
            if (timedOut) begin
                $display("test %0d %s: timed out", r, rows[r].name);
            end else if (rowErrors == 0) begin
                $display("test %0d %s: ok", r, rows[r].name);
            end else begin
                $display("test %0d %s: %0d wrong values", r, rows[r].name, rowErrors);
            end
            if (timedOut || rowErrors != 0) begin
                failedTests++;
            end
        end
        assertFails = dut_i.assertions_i.failures;
        $display("tests run %0d, failed %0d, assertion failures %0d",
                 testsRun, failedTests, assertFails);
        if (failedTests == 0 && assertFails == 0 && !timedOut) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tests/qtuFmb_assertions.sv
module qtuFmb_assertions import routingTypesPkg::*; (
    input logic     clk,
    input logic     nrst,
    input logic     pktValid,
    input logic     pktReady,
    input logic     done,
    input nodeIdT   sourceId,
    input qValueT   qValue,
    input hopCountT hopsFromCH,
    input nodeIdT   chosenCH,
    input logic     iAmDestination
);

    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench at the end of the run
    int failures = 0;

    // done is a status pulse, never two cycles long
    donePulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failures++;
        end

    // accept, then ready low through process and output, then done
    readyLowUntilDone: assert property (@(posedge clk) disable iff (!nrst)
        (pktValid && pktReady) |=> !pktReady ##1 !pktReady ##1 done)
        else begin
            $error("pktReady rose or done missed after an accepted packet");
            failures++;
        end

    // sender holds valid and the fields while back-pressured
    fieldsHeld: assert property (@(posedge clk) disable iff (!nrst)
        (pktValid && !pktReady) |=> pktValid && $stable(sourceId) && $stable(qValue)
            && $stable(hopsFromCH) && $stable(chosenCH) && $stable(iAmDestination))
        else begin
            $error("packet fields changed while waiting for pktReady");
            failures++;
        end

endmodule

bind qtuFmbTop qtuFmb_assertions assertions_i (
    .clk            (clk),
    .nrst           (nrst),
    .pktValid       (pktValid),
    .pktReady       (pktReady),
    .done           (done),
    .sourceId       (sourceId),
    .qValue         (qValue),
    .hopsFromCH     (hopsFromCH),
    .chosenCH       (chosenCH),
    .iAmDestination (iAmDestination)
);
